// File: gsm_tile.f
hw/gsm_pkg.sv
hw/gsm_if.sv
hw/ingress_mux.sv
hw/cell_buffer.sv
hw/egress_sched.sv
hw/gsm_tile.sv
sim/clk_gen.sv
sim/gsm_tile_tb.sv

// File: Makefile
# Verilator lint and simulation of the switch tile

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module gsm_tile -f gsm_tile.f

sim:
	verilator --binary --timing -Wno-fatal --top-module gsm_tile_tb -f gsm_tile.f -o gsm_tile_sim
	./obj_dir/gsm_tile_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/gsm_tile_tb.sv
/* testbench for the switch tile, per-source reference lists checked
   against every egress transfer */
module gsm_tile_tb import gsm_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 20000;        // ~290 cells * 4 ports * 8 cycles plus margin
	localparam int CAPACITY       = NUM_CELLS + 2; // buffer, port 1 output reg, capture reg
	localparam int NUM_LISTS      = NUM_PORTS * NUM_PORTS;

	logic                  clk_320M;
	logic                  rst;
	logic [NUM_PORTS-1:0]  in_valid;
	logic [NUM_PORTS-1:0]  in_ready;
	cell_t [NUM_PORTS-1:0] in_data;
	logic [NUM_PORTS-1:0]  eg_valid;
	logic [NUM_PORTS-1:0]  eg_ready;
	cell_t [NUM_PORTS-1:0] eg_data;

	cell_t send_q [NUM_PORTS][$];   // cells still to offer per ingress port
	cell_t exp_q  [NUM_LISTS][$];   // expected copies indexed by egress*4 + source
	int    gap      [NUM_PORTS];    // idle cycles before the next offer
	int    accepted [NUM_PORTS];
	logic [NUM_PORTS-1:0] ready_force = '1;
	logic  ready_random = 1'b0;     // random i_eg_ready every cycle
	logic  gap_random   = 1'b0;
	int    seq = 0;
	int    errors = 0;
	int    checks = 0;
	int    copies = 0;
	int    cycles = 0;
	int    test_errors = 0;

	clk_gen u_clk_gen (.o_clk(clk_320M), .o_rst(rst));

	gsm_tile u_dut (
		.i_clk_320M (clk_320M),
		.i_rst      (rst),
		.i_in_valid (in_valid),
		.o_in_ready (in_ready),
		.i_in_data  (in_data),
		.o_eg_valid (eg_valid),
		.i_eg_ready (eg_ready),
		.o_eg_data  (eg_data)
	);

	// --------------------
	// reference model
	// one copy per set mask bit and none for a zero mask
	function automatic void model_accept(input cell_t c);
		int src;
		src = int'(c[7:4]);
		for (int e = 0; e < NUM_PORTS; e++) begin
			if (c[e])
				exp_q[e*NUM_PORTS + src].push_back(c);
		end
	endfunction

	// {sequence, source, mask}
	function automatic cell_t make_cell(input int src, input port_mask_t mask);
		seq++;
		return {seq[23:0], 4'(src), mask};
	endfunction

	function automatic int accepted_total();
		int n;
		n = 0;
		for (int p = 0; p < NUM_PORTS; p++)
			n += accepted[p];
		return n;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// stimulus 1 unit after the rising edge
	always @(posedge clk_320M) begin
		#1;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (gap[p] > 0) begin
				gap[p]      = gap[p] - 1;
				in_valid[p] = 1'b0;
			end else if (send_q[p].size() > 0) begin
				in_valid[p] = 1'b1;          // front held until accepted
				in_data[p]  = send_q[p][0];
			end else begin
				in_valid[p] = 1'b0;
			end
		end
		eg_ready = ready_random ? NUM_PORTS'($urandom) : ready_force;
	end

	// ingress transfers sampled mid-cycle where inputs are stable
	always @(negedge clk_320M) begin
		if (!rst) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (in_valid[p] && in_ready[p]) begin
					model_accept(in_data[p]);
					void'(send_q[p].pop_front());
					accepted[p]++;
					if (gap_random)
						gap[p] = $urandom_range(3);
				end
			end
		end
	end

	// egress compare against the head of the list for port and source
	always @(negedge clk_320M) begin
		int src;
		if (!rst) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (eg_valid[p] && eg_ready[p]) begin
					src = int'(eg_data[p][7:4]);
					copies++;
					if (src >= NUM_PORTS || exp_q[p*NUM_PORTS + src].size() == 0) begin
						$display("%0t: unexpected cell %h on egress port %0d",
							$time, eg_data[p], p);
						errors++;
					end else begin
						check_value($sformatf("o_eg_data[%0d]", p), eg_data[p],
							exp_q[p*NUM_PORTS + src].pop_front());
					end
				end
			end
		end
	end

	// watchdog
	always @(posedge clk_320M) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------
	// helpers
	task automatic wait_drain();
		int pending;
		do begin
			@(posedge clk_320M);
			pending = 0;
			for (int i = 0; i < NUM_LISTS; i++)
				pending += exp_q[i].size();
			for (int p = 0; p < NUM_PORTS; p++)
				pending += send_q[p].size();
		end while (pending != 0);
		repeat (20) @(posedge clk_320M); // room for stray copies to show up
	endtask

	// returns once port p has taken nothing for 40 cycles
	task automatic wait_stall(input int p);
		int last;
		int idle;
		last = accepted[p];
		idle = 0;
		while (idle < 40) begin
			@(posedge clk_320M);
			if (accepted[p] != last) begin
				last = accepted[p];
				idle = 0;
			end else begin
				idle++;
			end
		end
	endtask

	task automatic end_test(input string name);
		$display("test %-13s %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// port 0 -> port 1 with every egress stalled and then released
	task automatic fill_and_drain(input string name);
		int base;
		base        = accepted[0];
		ready_force = '0;
		repeat (CAPACITY + 1)
			send_q[0].push_back(make_cell(0, 4'b0010));
		wait_stall(0);
		check_value("accepted cells", 32'(accepted[0] - base), 32'(CAPACITY));
		ready_force = '1;
		wait_drain();
		end_test(name);
	endtask

	// --------------------
	// test sequence
	initial begin
		int base;
		int p;
		in_valid = '0;
		in_data  = '0;
		eg_ready = '1;
		for (int i = 0; i < NUM_PORTS; i++) begin
			gap[i]      = 0;
			accepted[i] = 0;
		end
		void'($urandom(76));
		@(negedge rst);
		@(posedge clk_320M);

		for (int s = 0; s < NUM_PORTS; s++) begin
			for (int i = 0; i < 8; i++)
				send_q[s].push_back(make_cell(s, port_mask_t'(1 << ((s + i) % NUM_PORTS))));
		end
		wait_drain();
		end_test("unicast");

		for (int s = 0; s < NUM_PORTS; s++) begin
			send_q[s].push_back(make_cell(s, 4'b1111)); // broadcast
			send_q[s].push_back(make_cell(s, 4'b0101));
		end
		wait_drain();
		end_test("multicast");

		base = accepted_total();
		for (int s = 0; s < NUM_PORTS; s++) begin
			send_q[s].push_back(make_cell(s, 4'b0000));
			send_q[s].push_back(make_cell(s, 4'b0000));
		end
		// count ingress handshakes once every port has gone quiet
		for (int s = 0; s < NUM_PORTS; s++)
			wait_stall(s);
		check_value("dropped cells accepted", 32'(accepted_total() - base), 32'(2 * NUM_PORTS));
		wait_drain();
		end_test("drop");

		fill_and_drain("backpressure");
		fill_and_drain("recovery");

		gap_random   = 1'b1;
		ready_random = 1'b1;
		repeat (200) begin
			p = $urandom_range(NUM_PORTS - 1);
			send_q[p].push_back(make_cell(p, port_mask_t'($urandom)));
		end
		wait_drain();
		ready_random = 1'b0;
		gap_random   = 1'b0;
		end_test("random");

		for (int i = 0; i < NUM_LISTS; i++) begin
			if (exp_q[i].size() != 0) begin
				$display("egress port %0d still waits for %0d cells from source %0d",
					i / NUM_PORTS, exp_q[i].size(), i % NUM_PORTS);
				errors++;
			end
		end
		$display("checks %0d, errors %0d, cells accepted %0d, copies received %0d",
			checks, errors, accepted_total(), copies);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: sim/clk_gen.sv
/* testbench clock and reset, period 10, reset held for 4 cycles */
module clk_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		o_rst = 1'b1;
		repeat (4) @(posedge o_clk);
		#1 o_rst = 1'b0; // released together with the other inputs
	end

	always #5 o_clk = ~o_clk;

endmodule

// File: hw/gsm_tile.sv
/* shared-memory switch tile, 4 ingress and 4 egress ports around
   one shared cell buffer */
module gsm_tile import gsm_pkg::*; (
	input  logic                  i_clk_320M,
	input  logic                  i_rst,

	// ingress ports
	input  logic [NUM_PORTS-1:0]  i_in_valid,
	output logic [NUM_PORTS-1:0]  o_in_ready,
	input  cell_t [NUM_PORTS-1:0] i_in_data,

	// egress ports
	output logic [NUM_PORTS-1:0]  o_eg_valid,
	input  logic [NUM_PORTS-1:0]  i_eg_ready,
	output cell_t [NUM_PORTS-1:0] o_eg_data
);

	// --------------------
	// internal channels
	cell_wr_if u_wr_if ();  // mux -> buffer
	cell_rd_if u_rd_if ();  // scheduler <-> buffer

	// producer
	ingress_mux u_ingress_mux (
		.i_clk_320M (i_clk_320M),
		.i_rst      (i_rst),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.i_in_data  (i_in_data),
		.wr         (u_wr_if.source)
	);

	// shared buffer
	cell_buffer u_cell_buffer (
		.i_clk_320M (i_clk_320M),
		.i_rst      (i_rst),
		.wr         (u_wr_if.sink),
		.rd         (u_rd_if.sink)
	);

	// consumer
	egress_sched u_egress_sched (
		.i_clk_320M (i_clk_320M),
		.i_rst      (i_rst),
		.rd         (u_rd_if.master),
		.o_eg_valid (o_eg_valid),
		.i_eg_ready (i_eg_ready),
		.o_eg_data  (o_eg_data)
	);

endmodule

// File: hw/egress_sched.sv
/* egress scheduler, round-robin reads of the egress queues into
   one output register per port with valid/ready */
module egress_sched import gsm_pkg::*; (
	input  logic                  i_clk_320M,
	input  logic                  i_rst,

	// buffer reads
	cell_rd_if.master             rd,

	// egress ports
	output logic [NUM_PORTS-1:0]  o_eg_valid,
	input  logic [NUM_PORTS-1:0]  i_eg_ready,
	output cell_t [NUM_PORTS-1:0] o_eg_data
);

	eg_state_t            state;
	port_idx_t            rr_ptr;   // first port to look at
	port_idx_t            cur_port; // port of the read in flight
	port_idx_t            pick;
	logic                 pick_valid;
	logic [NUM_PORTS-1:0] eligible;

	// --------------------
	// port choice
	// output register free = empty or leaving this cycle
	assign eligible = rd.q_nonempty & (~o_eg_valid | i_eg_ready);

	always_comb begin
		port_idx_t idx;
		pick_valid = 1'b0;
		pick       = rr_ptr;
		// walk backwards so the nearest port to rr_ptr wins
		for (int k = NUM_PORTS - 1; k >= 0; k--) begin
			idx = rr_ptr + port_idx_t'(k);
			if (eligible[idx]) begin
				pick_valid = 1'b1;
				pick       = idx;
			end
		end
	end

	assign rd.rd_req  = (state == EG_IDLE) && pick_valid; // one read in flight at most
	assign rd.rd_port = pick;

	// --------------------
	// read FSM and output valids
	always_ff @(posedge i_clk_320M) begin
		if (i_rst) begin
			state      <= EG_IDLE;
			rr_ptr     <= '0;
			cur_port   <= '0;
			o_eg_valid <= '0;
		end else begin
			case (state)
				EG_IDLE: begin
					if (rd.rd_req) begin
						state    <= EG_READ;
						cur_port <= pick;
						rr_ptr   <= pick + 1'b1; // next search starts after it
					end
				end
				EG_READ: begin
					if (rd.rd_ack)
						state <= EG_IDLE;
				end
				default: state <= EG_IDLE;
			endcase
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (rd.rd_ack && (cur_port == port_idx_t'(p)))
					o_eg_valid[p] <= 1'b1;      // register was freed when requested
				else if (i_eg_ready[p])
					o_eg_valid[p] <= 1'b0;      // transfer done
			end
		end
	end

	// output data held until the transfer
	always_ff @(posedge i_clk_320M) begin
		if (rd.rd_ack)
			o_eg_data[cur_port] <= rd.rd_cell;
	end

endmodule

// File: hw/cell_buffer.sv
/* shared cell buffer, free pointer list, per-cell reference counts
   and one address queue per egress port */
module cell_buffer import gsm_pkg::*; (
	input  logic     i_clk_320M,
	input  logic     i_rst,
	cell_wr_if.sink  wr,
	cell_rd_if.sink  rd
);

	// --------------------
	// storage
	cell_t            cell_mem [NUM_CELLS];              // shared cell memory
	logic [REF_W-1:0] ref_cnt  [NUM_CELLS];              // copies still to read
	cell_addr_t       fl_mem   [NUM_CELLS];              // circular free list
	cell_addr_t       fl_rd;                             // next address to hand out
	cell_addr_t       fl_wr;                             // next slot for a freed address
	logic [CNT_W-1:0] fl_cnt;                            // free addresses
	cell_addr_t       q_mem    [NUM_PORTS][NUM_CELLS];   // egress address queues
	cell_addr_t       q_rd     [NUM_PORTS];
	cell_addr_t       q_wr     [NUM_PORTS];
	logic [CNT_W-1:0] q_cnt    [NUM_PORTS];             // never above NUM_CELLS

	logic             alloc;      // write that takes an address
	cell_addr_t       alloc_addr;
	cell_addr_t       head_addr;  // head of the queue being read
	logic             free_addr;  // last copy read
	port_mask_t       q_push;
	port_mask_t       q_pop;
	logic [REF_W-1:0] copies;

	// --------------------
	// write side
	assign wr.wr_ready = (fl_cnt != '0);
	// zero mask is accepted and dropped, no address used
	assign alloc       = wr.wr_valid && wr.wr_ready && (wr.wr_mask != '0);
	assign alloc_addr  = fl_mem[fl_rd];
	assign q_push      = alloc ? wr.wr_mask : '0;

	always_comb begin
		copies = '0;
		for (int p = 0; p < NUM_PORTS; p++)
			copies = copies + REF_W'(wr.wr_mask[p]); // one copy per set bit
	end

	// read side
	assign head_addr = q_mem[rd.rd_port][q_rd[rd.rd_port]];
	assign free_addr = rd.rd_req && (ref_cnt[head_addr] == REF_W'(1));

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			q_pop[p]         = rd.rd_req && (rd.rd_port == port_idx_t'(p));
			rd.q_nonempty[p] = (q_cnt[p] != '0);
		end
	end

	// --------------------
	// payload, refcounts, queue entries
	// alloc_addr is free and head_addr is in use, so never the same cell
	always_ff @(posedge i_clk_320M) begin
		if (alloc) begin
			cell_mem[alloc_addr] <= wr.wr_cell;
			ref_cnt[alloc_addr]  <= copies;
		end
		if (rd.rd_req) begin
			ref_cnt[head_addr] <= ref_cnt[head_addr] - 1'b1; // same cycle as pop
			rd.rd_cell         <= cell_mem[head_addr];
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (q_push[p])
				q_mem[p][q_wr[p]] <= alloc_addr;
		end
	end

	// --------------------
	// pointers and counts
	always_ff @(posedge i_clk_320M) begin
		if (i_rst) begin
			fl_rd     <= '0;
			fl_wr     <= '0;                 // list full, wr wraps onto rd
			fl_cnt    <= CNT_W'(NUM_CELLS);
			rd.rd_ack <= 1'b0;
			for (int a = 0; a < NUM_CELLS; a++)
				fl_mem[a] <= cell_addr_t'(a); // every address free
			for (int p = 0; p < NUM_PORTS; p++) begin
				q_rd[p]  <= '0;
				q_wr[p]  <= '0;
				q_cnt[p] <= '0;
			end
		end else begin
			rd.rd_ack <= rd.rd_req; // answer exactly one cycle later
			if (alloc)
				fl_rd <= fl_rd + 1'b1;
			if (free_addr) begin
				fl_mem[fl_wr] <= head_addr; // back to the free list
				fl_wr         <= fl_wr + 1'b1;
			end
			fl_cnt <= fl_cnt + CNT_W'(free_addr) - CNT_W'(alloc);
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (q_push[p])
					q_wr[p] <= q_wr[p] + 1'b1;
				if (q_pop[p])
					q_rd[p] <= q_rd[p] + 1'b1;
				q_cnt[p] <= q_cnt[p] + CNT_W'(q_push[p]) - CNT_W'(q_pop[p]);
			end
		end
	end

endmodule

// File: hw/ingress_mux.sv
/* ingress mux, one capture register per port and a rotating one-hot
   selector offering one cell per cycle to the shared buffer */
module ingress_mux import gsm_pkg::*; (
	input  logic                 i_clk_320M,
	input  logic                 i_rst,

	// ingress ports
	input  logic [NUM_PORTS-1:0] i_in_valid,
	output logic [NUM_PORTS-1:0] o_in_ready,
	input  cell_t [NUM_PORTS-1:0] i_in_data,

	// towards the buffer
	cell_wr_if.source            wr
);

	logic [NUM_PORTS-1:0]  cap_valid; // capture register full
	cell_t [NUM_PORTS-1:0] cap_data;
	logic [NUM_PORTS-1:0]  sel;       // one-hot, current port
	logic [NUM_PORTS-1:0]  take;      // per-port ingress transfer
	logic [NUM_PORTS-1:0]  sent;      // per-port transfer to buffer
	logic                  wr_fire;
	cell_t                 sel_cell;

	// --------------------
	// capture registers
	assign o_in_ready = ~cap_valid; // one entry, ready while empty
	assign take       = i_in_valid & o_in_ready;
	assign wr_fire    = wr.wr_valid && wr.wr_ready;
	assign sent       = wr_fire ? sel : '0;

	always_ff @(posedge i_clk_320M) begin
		if (i_rst) begin
			cap_valid <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (take[p])
					cap_valid[p] <= 1'b1;
				else if (sent[p])
					cap_valid[p] <= 1'b0; // handed to the buffer
			end
		end
	end

	always_ff @(posedge i_clk_320M) begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (take[p])
				cap_data[p] <= i_in_data[p];
		end
	end

	// --------------------
	// rotating selector
	// holds while an offer waits for wr_ready, otherwise moves on
	always_ff @(posedge i_clk_320M) begin
		if (i_rst)
			sel <= NUM_PORTS'(1); // start at port 0
		else if (!(wr.wr_valid && !wr.wr_ready))
			sel <= {sel[NUM_PORTS-2:0], sel[NUM_PORTS-1]};
	end

	// one-hot and-or mux
	always_comb begin
		sel_cell = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (sel[p])
				sel_cell = sel_cell | cap_data[p];
		end
	end

	assign wr.wr_valid = |(sel & cap_valid);
	assign wr.wr_cell  = sel_cell;
	assign wr.wr_mask  = port_mask_t'(sel_cell[NUM_PORTS-1:0]); // routing mask in low bits

endmodule

// File: hw/gsm_if.sv
/* cell write and read channels between ingress mux, cell buffer
   and egress scheduler */

// --------------------
// cell write, ingress mux -> buffer
interface cell_wr_if import gsm_pkg::*; ();
	logic       wr_valid; // cell offered
	logic       wr_ready; // free address available
	cell_t      wr_cell;
	port_mask_t wr_mask;  // destination egress ports

	modport source (
		output wr_valid,
		output wr_cell,
		output wr_mask,
		input  wr_ready
	);

	modport sink (
		input  wr_valid,
		input  wr_cell,
		input  wr_mask,
		output wr_ready
	);
endinterface

// --------------------
// queue reads, scheduler -> buffer
interface cell_rd_if import gsm_pkg::*; ();
	port_mask_t q_nonempty; // one bit per egress queue
	logic       rd_req;     // pop head of queue rd_port
	port_idx_t  rd_port;
	cell_t      rd_cell;    // valid with rd_ack
	logic       rd_ack;     // one cycle after rd_req

	modport master (
		input  q_nonempty,
		output rd_req,
		output rd_port,
		input  rd_cell,
		input  rd_ack
	);

	modport sink (
		output q_nonempty,
		input  rd_req,
		input  rd_port,
		output rd_cell,
		output rd_ack
	);
endinterface

// File: hw/gsm_pkg.sv
/* shared-memory switch tile definitions
   sizes, cell and address types, egress read states */
package gsm_pkg;

	// --------------------
	// tile sizes
	localparam int NUM_PORTS = 4;                  // ingress and egress ports
	localparam int CELL_W    = 32;                 // one cell = one word
	localparam int NUM_CELLS = 16;                 // shared buffer depth
	localparam int ADDR_W    = $clog2(NUM_CELLS);  // cell address width
	localparam int PORT_W    = $clog2(NUM_PORTS);  // port index width
	localparam int CNT_W     = ADDR_W + 1;         // occupancy 0..NUM_CELLS
	localparam int REF_W     = $clog2(NUM_PORTS + 1); // copies 0..NUM_PORTS

	// --------------------
	// cell and address types
	typedef logic [NUM_PORTS-1:0] port_mask_t;  // one bit per egress port
	typedef logic [CELL_W-1:0]    cell_t;       // mask sits in the low bits
	typedef logic [ADDR_W-1:0]    cell_addr_t;
	typedef logic [PORT_W-1:0]    port_idx_t;

	// egress read machine
	typedef enum logic {
		EG_IDLE, // pick a queue
		EG_READ  // wait for the buffer answer
	} eg_state_t;

endpackage
